// ==== bench/mon_model.svh ====
`ifndef MON_MODEL_SVH
`define MON_MODEL_SVH

// --------------------
// random source
// --------------------
// 16-bit Galois LFSR, one step per bit
logic [15:0] lfsr_state = 16'd8489;

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
   if (s[0]) return (s >> 1) ^ 16'hb400;
   else      return s >> 1;
endfunction

function automatic int unsigned take_bits(input int n);
   int unsigned v;
   v = 0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
   end
   return v;
endfunction

// --------------------
// counter model
// --------------------
int unsigned     m_good;
int unsigned     m_bad;
int unsigned     m_target;
longint unsigned m_bytes;
bit              m_active;
bit              m_done;

task automatic model_clear(input int unsigned tgt);
   m_good   = 0;
   m_bad    = 0;
   m_bytes  = 0;
   m_target = tgt;
   m_active = 1'b0;
   m_done   = 1'b0;
endtask

// a stop ends the run without the count reaching the target
task automatic freeze_model();
   m_active = 1'b0;
   m_done   = 1'b1;
endtask

// one clock edge with the beat that is on the stream
task automatic model_edge(input bit valid, input bit sop, input bit eop,
                          input int unsigned empty, input int unsigned err);
   bit hit;
   hit = ((m_good + m_bad) == m_target);
   if (m_active && valid) begin
      if (eop) m_bytes += 64'(beat_bytes - empty);
      else     m_bytes += 64'(beat_bytes);
      if (eop && err != 0) m_bad++;
      else if (eop)        m_good++;
   end
   // done shows one edge after the count reaches the target
   if (m_active) begin
      if (hit) begin
         m_active = 1'b0;
         m_done   = 1'b1;
      end
   end else if (!m_done && valid && sop) begin
      m_active = 1'b1;
   end
endtask

`endif

// ==== bench/tb_pkt_monitor.sv ====
`timescale 1ns/1ps

module tb_pkt_monitor;
   import mon_pkg::*;

   localparam int beat_bytes = 8;
   localparam int wait_limit = 400;

   logic              clk;
   logic              reset;
   logic [addr_w-1:0] address;
   logic              write;
   logic              read;
   logic [data_w-1:0] writedata;
   logic              waitrequest;
   logic [data_w-1:0] readdata;
   logic [63:0]       rx_data;
   logic              rx_valid;
   logic              rx_sop;
   logic              rx_eop;
   logic [empty_w-1:0] rx_empty;
   logic [err_w-1:0]  rx_error;
   logic              rx_ready;
   logic              start;
   logic              pkt_clear;
   logic              stop_mon;
   logic              mon_active;
   logic              mon_done;
   logic              mon_error;

   int unsigned errors = 0;
   int unsigned seen_active = 0;
   int unsigned last_err_sent = 0;

   `include "mon_model.svh"

   pkt_monitor #(.stream_w(64)) dut0 (
      .clk(clk), .reset(reset),
      .address(address), .write(write), .read(read), .writedata(writedata),
      .waitrequest(waitrequest), .readdata(readdata),
      .rx_data(rx_data), .rx_valid(rx_valid), .rx_sop(rx_sop), .rx_eop(rx_eop),
      .rx_empty(rx_empty), .rx_error(rx_error), .rx_ready(rx_ready),
      .start(start), .pkt_clear(pkt_clear), .stop_mon(stop_mon),
      .mon_active(mon_active), .mon_done(mon_done), .mon_error(mon_error)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // edges with the run active, for the cycle counter
   always @(posedge clk) begin
      if (mon_active) seen_active <= seen_active + 1;
   end

   // --------------------
   // reporting
   // --------------------
   task automatic final_report();
      $display("checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   endtask

   task automatic give_up(input string what);
      errors++;
      $display("timeout at %0t while waiting for %s", $time, what);
      final_report();
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // --------------------
   // bus and stream drivers
   // --------------------
   task automatic bus_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      address   = a;
      writedata = d;
      write     = 1'b1;
      do begin
         @(posedge clk);
         #1;
         n++;
         if (n > wait_limit) give_up("write waitrequest");
      end while (waitrequest);
      write = 1'b0;
   endtask

   task automatic bus_read(input logic [addr_w-1:0] a, output logic [data_w-1:0] d);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      address = a;
      read    = 1'b1;
      do begin
         @(posedge clk);
         #1;
         n++;
         if (n > wait_limit) give_up("read waitrequest");
      end while (waitrequest);
      d    = readdata;
      read = 1'b0;
   endtask

   task automatic read_wide(input logic [addr_w-1:0] lo, output logic [63:0] v);
      logic [data_w-1:0] l;
      logic [data_w-1:0] h;
      bus_read(lo, l);
      bus_read(lo + 8'd1, h);
      v = {h, l};
   endtask

   task automatic drive_beat(input bit valid, input bit sop, input bit eop,
                             input int unsigned empty, input int unsigned err);
      @(posedge clk);
      #1;
      rx_valid = valid;
      rx_sop   = sop;
      rx_eop   = eop;
      rx_empty = empty_w'(empty);
      rx_error = err_w'(err);
      rx_data  = {4{lfsr_state}};
      model_edge(valid, sop, eop, empty, err);
   endtask

   task automatic send_packet(input bit force_bad);
      int unsigned len;
      int unsigned empty;
      int unsigned err;
      len   = 2 + take_bits(2);
      empty = take_bits(3);
      err   = (take_bits(2) == 0) ? take_bits(6) : 0;
      if (force_bad) err = err | 1;
      for (int unsigned i = 0; i < len; i++) begin
         if (i == len - 1) drive_beat(1'b1, i == 0, 1'b1, empty, err);
         else              drive_beat(1'b1, i == 0, 1'b0, 0, 0);
      end
      last_err_sent = err;
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      drive_beat(1'b0, 1'b0, 1'b0, 0, 0);
      while (!mon_done) begin
         n++;
         if (n > wait_limit) give_up("mon_done");
         drive_beat(1'b0, 1'b0, 1'b0, 0, 0);
      end
   endtask

   task automatic pulse(ref logic sig);
      @(posedge clk);
      #1;
      sig = 1'b1;
      @(posedge clk);
      #1;
      sig = 1'b0;
   endtask

   // --------------------
   // test sequence
   // --------------------
   initial begin
      logic [data_w-1:0] d;
      logic [63:0]       w;
      int unsigned       seen_base;
      int unsigned       npkt;

      reset = 1'b1;
      address = '0;
      write = 1'b0;
      read = 1'b0;
      writedata = '0;
      rx_data = '0;
      rx_valid = 1'b0;
      rx_sop = 1'b0;
      rx_eop = 1'b0;
      rx_empty = '0;
      rx_error = '0;
      start = 1'b0;
      pkt_clear = 1'b0;
      stop_mon = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      // after reset
      bus_read(reg_target, d);
      check_value("target after reset", 64'(d), 64'hffff_ffff);
      bus_read(reg_good, d);
      check_value("good after reset", 64'(d), 64'd0);
      bus_read(reg_bad, d);
      check_value("bad after reset", 64'(d), 64'd0);
      read_wide(reg_bytes_lo, w);
      check_value("bytes after reset", w, 64'd0);
      read_wide(reg_cycles_lo, w);
      check_value("cycles after reset", w, 64'd0);
      read_wide(reg_total_good_lo, w);
      check_value("total good after reset", w, 64'd0);
      read_wide(reg_total_bad_lo, w);
      check_value("total bad after reset", w, 64'd0);
      check_value("flags after reset", {61'd0, mon_active, mon_done, mon_error}, 64'd0);
      check_value("rx_ready", 64'(rx_ready), 64'd1);

      // random run up to the target
      npkt = 12;
      bus_write(reg_target, npkt);
      bus_write(reg_csr, 32'd1);
      model_clear(npkt);
      seen_base = seen_active;
      for (int unsigned i = 0; i < npkt; i++) send_packet(i == npkt - 1);
      wait_done();
      check_value("mon_active after run", 64'(mon_active), 64'd0);
      bus_read(reg_good, d);
      check_value("good count", 64'(d), 64'(m_good));
      bus_read(reg_bad, d);
      check_value("bad count", 64'(d), 64'(m_bad));
      read_wide(reg_bytes_lo, w);
      check_value("byte count", w, m_bytes);
      read_wide(reg_cycles_lo, w);
      check_value("cycle count", w, 64'(seen_active - seen_base));

      // status bits, bad flag clears on read
      bus_read(reg_csr, d);
      check_value("csr done bit", 64'(d[2]), 64'd1);
      check_value("bad flag first read", 64'(d[3]), 64'd1);
      check_value("last error", 64'(d[9:4]), 64'(last_err_sent));
      bus_read(reg_csr, d);
      check_value("bad flag second read", 64'(d[3]), 64'd0);
      check_value("mon_error", 64'(mon_error), 64'd1);

      // sticky totals against per-run counts
      read_wide(reg_total_good_lo, w);
      check_value("total good", w, 64'(m_good));
      read_wide(reg_total_bad_lo, w);
      check_value("total bad", w, 64'(m_bad));
      pulse(pkt_clear);
      read_wide(reg_total_good_lo, w);
      check_value("total good after clear", w, 64'd0);
      read_wide(reg_total_bad_lo, w);
      check_value("total bad after clear", w, 64'd0);
      bus_read(reg_good, d);
      check_value("good after clear", 64'(d), 64'(m_good));
      bus_read(reg_bad, d);
      check_value("bad after clear", 64'(d), 64'(m_bad));

      // stop request during a long run
      bus_write(reg_target, 32'd1000);
      bus_write(reg_csr, 32'd1);
      model_clear(1000);
      for (int i = 0; i < 3; i++) send_packet(1'b0);
      stop_mon = 1'b1;
      wait_done();
      check_value("mon_active after stop", 64'(mon_active), 64'd0);
      freeze_model();
      for (int i = 0; i < 3; i++) send_packet(1'b0);
      drive_beat(1'b0, 1'b0, 1'b0, 0, 0);
      bus_read(reg_good, d);
      check_value("good frozen after stop", 64'(d), 64'(m_good));
      bus_read(reg_bad, d);
      check_value("bad frozen after stop", 64'(d), 64'(m_bad));
      read_wide(reg_bytes_lo, w);
      check_value("bytes frozen after stop", w, m_bytes);
      stop_mon = 1'b0;

      // start zeroes per-run counts and totals
      pulse(start);
      bus_read(reg_good, d);
      check_value("good after start", 64'(d), 64'd0);
      bus_read(reg_bad, d);
      check_value("bad after start", 64'(d), 64'd0);
      read_wide(reg_total_good_lo, w);
      check_value("total good after start", w, 64'd0);
      read_wide(reg_total_bad_lo, w);
      check_value("total bad after start", w, 64'd0);

      final_report();
   end

endmodule

// ==== design/csr_bank.sv ====
`timescale 1ns/1ps

module csr_bank (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [mon_pkg::addr_w-1:0] address,
   input  logic                       write,
   input  logic                       read,
   input  logic [mon_pkg::data_w-1:0] writedata,
   input  logic                       mon_done,
   input  logic                       rx_valid,
   input  logic                       rx_eop,
   input  logic [mon_pkg::err_w-1:0]  rx_error,
   input  logic [mon_pkg::cnt_w-1:0]  good_cnt,
   input  logic [mon_pkg::cnt_w-1:0]  bad_cnt,
   input  logic [mon_pkg::wide_w-1:0] total_good,
   input  logic [mon_pkg::wide_w-1:0] total_bad,
   input  logic [mon_pkg::wide_w-1:0] byte_cnt,
   input  logic [mon_pkg::wide_w-1:0] cycle_cnt,
   output logic                       waitrequest,
   output logic [mon_pkg::data_w-1:0] readdata,
   output logic                       init_pulse,
   output logic [mon_pkg::cnt_w-1:0]  target
);
   import mon_pkg::*;

   reg_addr_e         reg_sel;
   logic              wr_dly;
   logic              rd_dly;
   logic              wr_edge;
   logic              rd_edge;
   logic              csr_wr;
   logic              csr_rd;
   logic [1:0]        ctrl;
   logic              init_dly;
   logic              bad_flag;
   logic [err_w-1:0]  last_err;
   logic              end_beat;
   logic [data_w-1:0] csr_word;

   assign reg_sel  = reg_addr_e'(address);
   assign csr_wr   = write & (reg_sel == reg_csr);
   assign csr_rd   = read & (reg_sel == reg_csr);
   assign end_beat = rx_valid & rx_eop;

   // --------------------
   // bus stall
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_dly <= 1'b0;
         rd_dly <= 1'b0;
      end else begin
         wr_dly <= write;
         rd_dly <= read;
      end
   end

   // first cycle of every new access waits
   assign wr_edge     = write & ~wr_dly;
   assign rd_edge     = read & ~rd_dly;
   assign waitrequest = wr_edge | rd_edge;

   // --------------------
   // writable registers
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         target <= target_reset;
      end else if (write && (reg_sel == reg_target)) begin
         target <= writedata[cnt_w-1:0];
      end
   end

   // init bit clears itself once the write ends
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrl <= '0;
      end else if (csr_wr) begin
         ctrl <= writedata[1:0];
      end else if (ctrl[0]) begin
         ctrl[0] <= 1'b0;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         init_dly <= 1'b0;
      end else begin
         init_dly <= ctrl[0];
      end
   end

   // one cycle per init write
   assign init_pulse = ctrl[0] & ~init_dly;

   // --------------------
   // status
   // --------------------
   // read of the csr wins over a new bad packet
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         bad_flag <= 1'b0;
         last_err <= '0;
      end else begin
         if (csr_rd)                       bad_flag <= 1'b0;
         else if (end_beat && |rx_error)   bad_flag <= 1'b1;
         if (end_beat) last_err <= rx_error;
      end
   end

   always_comb begin
      csr_word            = '0;
      csr_word[1:0]       = ctrl;
      csr_word[2]         = mon_done;
      csr_word[3]         = bad_flag;
      csr_word[4 +: err_w] = last_err;
   end

   // --------------------
   // read mux
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (read) begin
         case (reg_sel)
            reg_target:        readdata <= target;
            reg_good:          readdata <= good_cnt;
            reg_bad:           readdata <= bad_cnt;
            reg_bytes_lo:      readdata <= byte_cnt[data_w-1:0];
            reg_bytes_hi:      readdata <= byte_cnt[wide_w-1:data_w];
            reg_cycles_lo:     readdata <= cycle_cnt[data_w-1:0];
            reg_cycles_hi:     readdata <= cycle_cnt[wide_w-1:data_w];
            reg_csr:           readdata <= csr_word;
            reg_total_good_lo: readdata <= total_good[data_w-1:0];
            reg_total_good_hi: readdata <= total_good[wide_w-1:data_w];
            reg_total_bad_lo:  readdata <= total_bad[data_w-1:0];
            reg_total_bad_hi:  readdata <= total_bad[wide_w-1:data_w];
            default:           readdata <= '0;
         endcase
      end
   end

endmodule

// ==== design/mon_pkg.sv ====
package mon_pkg;

   // --------------------
   // bus and field widths
   // --------------------
   localparam int addr_w  = 8;
   localparam int data_w  = 32;

   // per-run counters
   localparam int cnt_w   = 32;
   // sticky totals, bytes and cycles
   localparam int wide_w  = 64;

   // stream side fields
   localparam int err_w   = 6;
   localparam int empty_w = 3;

   // no run ends before a target is written
   localparam logic [cnt_w-1:0] target_reset = '1;

   // --------------------
   // run state
   // --------------------
   typedef enum logic [1:0] {
      mon_idle   = 2'd0,
      mon_active = 2'd1,
      mon_done   = 2'd2
   } mon_state_e;

   // --------------------
   // register map
   // --------------------
   typedef enum logic [addr_w-1:0] {
      reg_target        = 8'h00,
      reg_good          = 8'h01,
      reg_bad           = 8'h02,
      reg_bytes_lo      = 8'h03,
      reg_bytes_hi      = 8'h04,
      reg_cycles_lo     = 8'h05,
      reg_cycles_hi     = 8'h06,
      reg_csr           = 8'h07,
      reg_total_good_lo = 8'h0d,
      reg_total_good_hi = 8'h0e,
      reg_total_bad_lo  = 8'h0f,
      reg_total_bad_hi  = 8'h10
   } reg_addr_e;

endpackage

// ==== design/pkt_monitor.sv ====
`timescale 1ns/1ps

module pkt_monitor #(
   parameter int stream_w = 64
) (
   input  logic                        clk,
   input  logic                        reset,
   // register bus
   input  logic [mon_pkg::addr_w-1:0]  address,
   input  logic                        write,
   input  logic                        read,
   input  logic [mon_pkg::data_w-1:0]  writedata,
   output logic                        waitrequest,
   output logic [mon_pkg::data_w-1:0]  readdata,
   // receive stream
   input  logic [stream_w-1:0]         rx_data,
   input  logic                        rx_valid,
   input  logic                        rx_sop,
   input  logic                        rx_eop,
   input  logic [mon_pkg::empty_w-1:0] rx_empty,
   input  logic [mon_pkg::err_w-1:0]   rx_error,
   output logic                        rx_ready,
   // run control
   input  logic                        start,
   input  logic                        pkt_clear,
   input  logic                        stop_mon,
   output logic                        mon_active,
   output logic                        mon_done,
   output logic                        mon_error
);
   import mon_pkg::*;

   logic              init_pulse;
   logic [cnt_w-1:0]  target;
   logic [cnt_w-1:0]  good_cnt;
   logic [cnt_w-1:0]  bad_cnt;
   logic [wide_w-1:0] total_good;
   logic [wide_w-1:0] total_bad;
   logic [wide_w-1:0] byte_cnt;
   logic [wide_w-1:0] cycle_cnt;

   // payload on rx_data is not inspected, only framing and flags

   run_control u_run (
      .clk        (clk),
      .reset      (reset),
      .init_pulse (init_pulse),
      .stop_mon   (stop_mon),
      .rx_valid   (rx_valid),
      .rx_sop     (rx_sop),
      .target     (target),
      .good_cnt   (good_cnt),
      .bad_cnt    (bad_cnt),
      .mon_active (mon_active),
      .mon_done   (mon_done),
      .mon_error  (mon_error),
      .rx_ready   (rx_ready)
   );

   traffic_counters #(
      .stream_w (stream_w)
   ) u_count (
      .clk        (clk),
      .reset      (reset),
      .init_pulse (init_pulse),
      .start      (start),
      .pkt_clear  (pkt_clear),
      .mon_active (mon_active),
      .rx_valid   (rx_valid),
      .rx_eop     (rx_eop),
      .rx_empty   (rx_empty),
      .rx_error   (rx_error),
      .good_cnt   (good_cnt),
      .bad_cnt    (bad_cnt),
      .total_good (total_good),
      .total_bad  (total_bad),
      .byte_cnt   (byte_cnt),
      .cycle_cnt  (cycle_cnt)
   );

   csr_bank u_csr (
      .clk         (clk),
      .reset       (reset),
      .address     (address),
      .write       (write),
      .read        (read),
      .writedata   (writedata),
      .mon_done    (mon_done),
      .rx_valid    (rx_valid),
      .rx_eop      (rx_eop),
      .rx_error    (rx_error),
      .good_cnt    (good_cnt),
      .bad_cnt     (bad_cnt),
      .total_good  (total_good),
      .total_bad   (total_bad),
      .byte_cnt    (byte_cnt),
      .cycle_cnt   (cycle_cnt),
      .waitrequest (waitrequest),
      .readdata    (readdata),
      .init_pulse  (init_pulse),
      .target      (target)
   );

endmodule

// ==== design/run_control.sv ====
`timescale 1ns/1ps

module run_control (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      init_pulse,
   input  logic                      stop_mon,
   input  logic                      rx_valid,
   input  logic                      rx_sop,
   input  logic [mon_pkg::cnt_w-1:0] target,
   input  logic [mon_pkg::cnt_w-1:0] good_cnt,
   input  logic [mon_pkg::cnt_w-1:0] bad_cnt,
   output logic                      mon_active,
   output logic                      mon_done,
   output logic                      mon_error,
   output logic                      rx_ready
);
   import mon_pkg::*;

   mon_state_e       state;
   mon_state_e       state_nxt;
   logic [3:0]       stop_sync;
   logic             stop_edge;
   logic [cnt_w-1:0] pkt_total;
   logic             count_hit;
   logic             set_done;
   logic             done_q;

   // --------------------
   // stop request
   // --------------------
   // three sync stages plus one for the edge
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stop_sync <= '0;
      end else begin
         stop_sync <= {stop_sync[2:0], stop_mon};
      end
   end

   assign stop_edge = stop_sync[2] & ~stop_sync[3];

   // --------------------
   // run completion
   // --------------------
   assign pkt_total = good_cnt + bad_cnt;
   assign count_hit = (pkt_total == target);
   assign set_done  = stop_edge | count_hit;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         done_q <= 1'b0;
      end else if (init_pulse) begin
         done_q <= 1'b0;
      end else if (set_done) begin
         done_q <= 1'b1;
      end
   end

   assign mon_done = done_q;

   // --------------------
   // run FSM
   // --------------------
   // active and done literals scoped, the ports carry the same names
   always_comb begin
      state_nxt = state;
      case (state)
         mon_idle: begin
            if (rx_valid && rx_sop) state_nxt = mon_pkg::mon_active;
         end
         mon_pkg::mon_active: begin
            // leave together with the done flag rising
            if (set_done || done_q) state_nxt = mon_pkg::mon_done;
         end
         mon_pkg::mon_done: begin
            state_nxt = mon_pkg::mon_done;
         end
         default: state_nxt = mon_idle;
      endcase
      if (init_pulse) state_nxt = mon_idle;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= mon_idle;
      end else begin
         state <= state_nxt;
      end
   end

   assign mon_active = (state == mon_pkg::mon_active);

   // sticky until reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mon_error <= 1'b0;
      end else if (done_q && (|bad_cnt)) begin
         mon_error <= 1'b1;
      end
   end

   // no back-pressure, ready once out of reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rx_ready <= 1'b0;
      end else begin
         rx_ready <= 1'b1;
      end
   end

endmodule

// ==== design/traffic_counters.sv ====
`timescale 1ns/1ps

module traffic_counters #(
   parameter int stream_w = 64
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        init_pulse,
   input  logic                        start,
   input  logic                        pkt_clear,
   input  logic                        mon_active,
   input  logic                        rx_valid,
   input  logic                        rx_eop,
   input  logic [mon_pkg::empty_w-1:0] rx_empty,
   input  logic [mon_pkg::err_w-1:0]   rx_error,
   output logic [mon_pkg::cnt_w-1:0]   good_cnt,
   output logic [mon_pkg::cnt_w-1:0]   bad_cnt,
   output logic [mon_pkg::wide_w-1:0]  total_good,
   output logic [mon_pkg::wide_w-1:0]  total_bad,
   output logic [mon_pkg::wide_w-1:0]  byte_cnt,
   output logic [mon_pkg::wide_w-1:0]  cycle_cnt
);
   import mon_pkg::*;

   // bytes carried by a full beat
   localparam logic [wide_w-1:0] beat_bytes = wide_w'(stream_w / 8);

   logic              pkt_end;
   logic              pkt_bad;
   logic              run_clear;
   logic              total_clear;
   logic [wide_w-1:0] beat_add;

   // packet ends only count inside a run
   assign pkt_end     = mon_active & rx_valid & rx_eop;
   // any error flag marks the packet bad
   assign pkt_bad     = |rx_error;
   assign run_clear   = init_pulse | start;
   assign total_clear = init_pulse | start | pkt_clear;

   // --------------------
   // packet counters
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         good_cnt <= '0;
         bad_cnt  <= '0;
      end else if (run_clear) begin
         good_cnt <= '0;
         bad_cnt  <= '0;
      end else if (pkt_end) begin
         if (pkt_bad) bad_cnt <= bad_cnt + 1'b1;
         else         good_cnt <= good_cnt + 1'b1;
      end
   end

   // sticky until start, pkt_clear or init
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         total_good <= '0;
         total_bad  <= '0;
      end else if (total_clear) begin
         total_good <= '0;
         total_bad  <= '0;
      end else if (pkt_end) begin
         if (pkt_bad) total_bad <= total_bad + 1'b1;
         else         total_good <= total_good + 1'b1;
      end
   end

   // --------------------
   // byte counter
   // --------------------
   // end beat drops the empty bytes
   always_comb begin
      beat_add = beat_bytes;
      if (rx_eop) beat_add = beat_bytes - wide_w'(rx_empty);
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         byte_cnt <= '0;
      end else if (init_pulse) begin
         byte_cnt <= '0;
      end else if (mon_active && rx_valid) begin
         byte_cnt <= byte_cnt + beat_add;
      end
   end

   // --------------------
   // active cycles
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cycle_cnt <= '0;
      end else if (init_pulse) begin
         cycle_cnt <= '0;
      end else if (mon_active) begin
         cycle_cnt <= cycle_cnt + 1'b1;
      end
   end

endmodule

// ==== pkt_monitor.f ====
+incdir+bench
design/mon_pkg.sv
design/run_control.sv
design/traffic_counters.sv
design/csr_bank.sv
design/pkt_monitor.sv
bench/tb_pkt_monitor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the packet monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f pkt_monitor.f \
   --top-module tb_pkt_monitor \
   -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "compile step failed, see build.log"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "tests failed" sim.log; then
   echo "simulation reported failures, see sim.log"
   exit 1
fi

if ! grep -q "all tests passed" sim.log; then
   echo "simulation ended without a result, see sim.log"
   exit 1
fi

echo "simulation passed"
exit 0
